//--- files.f
+incdir+logic
logic/lsb_pkg.sv
logic/sb_entry.sv
logic/sb_alloc.sv
logic/sb_forward.sv
logic/dcache_port.sv
logic/load_align.sv
logic/ldst_buffer.sv
tests/tb_dcache_model.sv
tests/tb_ldst_buffer.sv

//--- logic/dcache_port.sv
// Cache side of the buffer with one open transaction at a time and no
// back-pressure from the cache. The pipeline must hold req_i while stall_o is high.
// A load that misses the buffer waits for it to empty before it is issued.

`default_nettype none

`include "lsb_macros.svh"

module dcache_port
  import lsb_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        flush_i,
  input  mem_req_t    req_i,
  input  sb_entry_t   head_entry_i,
  input  logic        empty_i,
  input  logic        full_i,
  input  logic        can_merge_tail_i,
  input  logic        fwd_hit_i,
  input  logic        fwd_partial_i,
  input  dcache_res_t dcache_res_i,
  output dcache_req_t dcache_req_o,
  output logic        dequeue_o,
  output logic        accept_store_o,
  output logic        stall_o,
  output logic        load_done_o,
  output mem_req_t    active_o
);

  logic     txn_q;
  logic     act_load_q;
  logic     drain_q;
  mem_req_t act_q;
  logic     is_load;
  logic     fwd;
  logic     drain_store;
  logic     issue_load;
  logic [1:0] head_lsb;

  assign is_load = req_i.valid && !req_i.is_store;
  assign fwd     = is_load && fwd_hit_i && !drain_q;

  assign accept_store_o = req_i.valid && req_i.is_store && !drain_q &&
                          (!full_i || can_merge_tail_i);

  // ==========================================================================
  // Issue arbitration
  // ==========================================================================
  assign drain_store = !txn_q && !empty_i && !fwd;
  assign issue_load  = !txn_q && empty_i && is_load && !drain_q &&
                       !fwd_hit_i && !fwd_partial_i;  // Word not in the buffer

  always_comb begin
    head_lsb = 2'd0;
    for (int b = `LSB_BYTES - 1; b >= 0; b--) begin
      if (head_entry_i.strb[b]) head_lsb = 2'(b);  // Lowest lane wins
    end
  end

  always_comb begin
    dcache_req_o = '0;
    if (drain_store) begin
      dcache_req_o.valid    = 1'b1;
      dcache_req_o.is_store = 1'b1;
      dcache_req_o.addr     = {head_entry_i.waddr, head_lsb};
      dcache_req_o.size     = mask_size(head_entry_i.strb);
      dcache_req_o.data     = head_entry_i.data >> {head_lsb, 3'b000};
    end else if (issue_load) begin
      dcache_req_o.valid = 1'b1;
      dcache_req_o.addr  = req_i.addr;
      dcache_req_o.size  = req_i.size;
    end
  end

  // ==========================================================================
  // Transaction and drain tracking
  // ==========================================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      txn_q      <= 1'b0;
      act_load_q <= 1'b0;
      drain_q    <= 1'b0;
    end else begin
      if (dcache_req_o.valid) begin
        txn_q      <= 1'b1;
        act_load_q <= issue_load;
      end else if (dcache_res_i.valid) begin
        txn_q <= 1'b0;
      end
      if (drain_q && empty_i && !txn_q) begin
        drain_q <= 1'b0;
      end else if (flush_i && (!empty_i || txn_q || accept_store_o)) begin
        drain_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_load) act_q <= req_i;  // Size, sign and low bits for alignment
  end

  // A load answered during drain is dropped and issued again afterwards
  assign load_done_o    = fwd || (txn_q && act_load_q && dcache_res_i.valid && !drain_q);
  assign stall_o        = drain_q || (req_i.valid && !accept_store_o && !load_done_o);
  assign dequeue_o      = drain_store;
  assign active_o       = act_q;

  // The cache only answers an open transaction
  a_res_in_txn: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dcache_res_i.valid |-> txn_q);

endmodule

`default_nettype wire

//--- logic/ldst_buffer.sv
// Load/store buffer between a pipeline memory stage and a data cache.
// Every store goes through the buffer; loads forward on a full hit, else
// wait for the buffer to drain. Hold req_i while stall_o is high.
// ld_valid_o marks the cycle a load is accepted, with ld_data_o extended.

`default_nettype none

`include "lsb_macros.svh"

module ldst_buffer
  import lsb_pkg::*;
#(
  parameter int unsigned DEPTH = `LSB_DEPTH
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  mem_req_t             req_i,
  output logic                 stall_o,
  output logic                 ld_valid_o,
  output logic [`LSB_XLEN-1:0] ld_data_o,
  output dcache_req_t          dcache_req_o,
  input  dcache_res_t          dcache_res_i
);

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  sb_entry_t            entries [DEPTH];
  logic [DEPTH-1:0]     can_merge;
  logic [DEPTH-1:0]     write;
  logic [DEPTH-1:0]     merge;
  logic [PTR_W-1:0]     head;
  logic [PTR_W-1:0]     newest;
  logic [CNT_W-1:0]     count;
  logic                 full;
  logic                 empty;
  logic                 dequeue;
  logic                 accept_store;
  logic                 fwd_hit;
  logic                 fwd_partial;
  logic [`LSB_XLEN-1:0] fwd_word;
  mem_req_t             active;

  assign empty = (count == '0);

  // ==========================================================================
  // Store buffer
  // ==========================================================================
  for (genvar i = 0; i < DEPTH; i++) begin : g_entry
    sb_entry sb_entry_i (
      .clk_i, .rst_ni, .req_i,
      .write_i(write[i]), .merge_i(merge[i]),
      .entry_o(entries[i]), .can_merge_o(can_merge[i])
    );
  end

  sb_alloc #(.DEPTH(DEPTH)) sb_alloc_i (
    .clk_i, .rst_ni, .req_i,
    .accept_store_i(accept_store), .can_merge_i(can_merge), .dequeue_i(dequeue),
    .write_o(write), .merge_o(merge),
    .head_o(head), .newest_o(newest), .count_o(count), .full_o(full)
  );

  sb_forward #(.DEPTH(DEPTH)) sb_forward_i (
    .entries_i(entries), .newest_i(newest), .count_i(count), .req_i,
    .hit_o(fwd_hit), .partial_o(fwd_partial), .word_o(fwd_word)
  );

  // ==========================================================================
  // Cache port and load result
  // ==========================================================================
  dcache_port dcache_port_i (
    .clk_i, .rst_ni, .flush_i, .req_i,
    .head_entry_i(entries[head]), .empty_i(empty), .full_i(full),
    .can_merge_tail_i(can_merge[newest]),
    .fwd_hit_i(fwd_hit), .fwd_partial_i(fwd_partial),
    .dcache_res_i, .dcache_req_o,
    .dequeue_o(dequeue), .accept_store_o(accept_store),
    .stall_o, .load_done_o(ld_valid_o), .active_o(active)
  );

  load_align load_align_i (
    .fwd_i(fwd_hit), .fwd_word_i(fwd_word), .cache_word_i(dcache_res_i.data),
    .req_i, .active_i(active), .data_o(ld_data_o)
  );

endmodule

`default_nettype wire

//--- logic/load_align.sv
// Load result alignment. Takes the forwarded word when fwd_i is high, else
// the cache word with the size and address of the open load.
// Output is only meaningful while ld_valid_o is high.

`default_nettype none

`include "lsb_macros.svh"

module load_align
  import lsb_pkg::*;
(
  input  logic                 fwd_i,
  input  logic [`LSB_XLEN-1:0] fwd_word_i,
  input  logic [`LSB_XLEN-1:0] cache_word_i,
  input  mem_req_t             req_i,
  input  mem_req_t             active_i,
  output logic [`LSB_XLEN-1:0] data_o
);

  mem_req_t             sel;
  logic [`LSB_XLEN-1:0] word;
  logic [7:0]           lane_b;
  logic [15:0]          lane_h;

  always_comb begin
    sel    = fwd_i ? req_i : active_i;
    word   = fwd_i ? fwd_word_i : cache_word_i;
    lane_b = word[{sel.addr[1:0], 3'b000} +: 8];
    lane_h = word[{sel.addr[1], 4'b0000} +: 16];
    case (sel.size)
      BYTE:    data_o = {{(`LSB_XLEN - 8){sel.sign & lane_b[7]}}, lane_b};
      HALF:    data_o = {{(`LSB_XLEN - 16){sel.sign & lane_h[15]}}, lane_h};
      WORD:    data_o = word;
      default: data_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/lsb_macros.svh
// Sizing for the load/store buffer. The byte lane logic assumes a 32-bit word
// with 4 byte lanes, so only LSB_DEPTH is meant to be changed.

`ifndef LSB_MACROS_SVH
`define LSB_MACROS_SVH

// Address and data width, one word
`define LSB_XLEN 32

// Byte lanes per word
`define LSB_BYTES 4

// Store buffer entries, 2 or more
`define LSB_DEPTH 4

`endif

//--- logic/lsb_pkg.sv
// Types shared by the load/store buffer and its cache port.
// Accesses are assumed naturally aligned; a misaligned halfword or word
// gives a strobe mask that does not match the address.

`default_nettype none

`include "lsb_macros.svh"

package lsb_pkg;

  typedef enum logic [1:0] {
    NO_SIZE = 2'b00,
    BYTE    = 2'b01,
    HALF    = 2'b10,
    WORD    = 2'b11
  } size_e;

  typedef struct packed {
    logic                  valid;
    logic                  is_store;
    logic [`LSB_XLEN-1:0]  addr;
    size_e                 size;
    logic                  sign;     // Sign-extend a load
    logic [`LSB_XLEN-1:0]  data;
  } mem_req_t;

  typedef struct packed {
    logic                  valid;
    logic                  is_store;
    logic [`LSB_XLEN-1:0]  addr;
    size_e                 size;
    logic [`LSB_XLEN-1:0]  data;     // Store data in the low bits
  } dcache_req_t;

  typedef struct packed {
    logic                  valid;
    logic [`LSB_XLEN-1:0]  data;     // Full read word
  } dcache_res_t;

  typedef struct packed {
    logic [`LSB_XLEN-1:2]  waddr;
    logic [`LSB_XLEN-1:0]  data;     // Bytes in their word lanes
    logic [`LSB_BYTES-1:0] strb;
  } sb_entry_t;

  // Byte lanes touched by an access
  function automatic logic [`LSB_BYTES-1:0] byte_mask(input logic [1:0] lsb, input size_e size);
    case (size)
      BYTE:    return `LSB_BYTES'(1) << lsb;
      HALF:    return `LSB_BYTES'(3) << {lsb[1], 1'b0};
      WORD:    return '1;
      default: return '0;
    endcase
  endfunction

  // Size that a strobe mask stands for, NO_SIZE if it is not a single access
  function automatic size_e mask_size(input logic [`LSB_BYTES-1:0] strb);
    case (strb)
      4'b0001, 4'b0010, 4'b0100, 4'b1000: return BYTE;
      4'b0011, 4'b1100:                   return HALF;
      4'b1111:                            return WORD;
      default:                            return NO_SIZE;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- logic/sb_alloc.sv
// Head, tail and count of the store buffer, with wrap at DEPTH.
// An accepted store merges into the newest entry when it can, else it is
// written at the tail. The caller must not accept a store that needs a new
// entry while the buffer is full.

`default_nettype none

`include "lsb_macros.svh"

module sb_alloc
  import lsb_pkg::*;
#(
  parameter int unsigned DEPTH = `LSB_DEPTH
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  mem_req_t                   req_i,
  input  logic                       accept_store_i,
  input  logic [DEPTH-1:0]           can_merge_i,
  input  logic                       dequeue_i,
  output logic [DEPTH-1:0]           write_o,
  output logic [DEPTH-1:0]           merge_o,
  output logic [$clog2(DEPTH)-1:0]   head_o,
  output logic [$clog2(DEPTH)-1:0]   newest_o,
  output logic [$clog2(DEPTH+1)-1:0] count_o,
  output logic                       full_o
);

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] tail_q;
  logic [PTR_W-1:0] newest;
  logic [CNT_W-1:0] count_q;
  logic             store_in;
  logic             do_merge;
  logic             do_write;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == LAST) ? '0 : p + 1'b1;
  endfunction

  assign newest   = (tail_q == '0) ? LAST : tail_q - 1'b1;
  assign store_in = accept_store_i && req_i.valid && req_i.is_store;

  // The newest entry cannot take a merge in the cycle it is sent to the cache
  assign do_merge = store_in && (count_q != '0) && can_merge_i[newest] &&
                    !(dequeue_i && (count_q == CNT_W'(1)));
  assign do_write = store_in && !do_merge;

  always_comb begin
    write_o         = '0;
    merge_o         = '0;
    write_o[tail_q] = do_write;
    merge_o[newest] = do_merge;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_write) tail_q <= next_ptr(tail_q);
      if (dequeue_i) head_q <= next_ptr(head_q);
      count_q <= count_q + CNT_W'(do_write) - CNT_W'(dequeue_i);
    end
  end

  assign head_o   = head_q;
  assign newest_o = newest;
  assign count_o  = count_q;
  assign full_o   = (count_q == CNT_W'(DEPTH));

  a_count_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= CNT_W'(DEPTH));

  // Store acceptance in the cache port must leave room for a new entry
  a_no_write_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    full_o |-> !do_write);

endmodule

`default_nettype wire

//--- logic/sb_entry.sv
// One store buffer entry. Whether it is occupied is tracked by the allocator,
// so strobes of a freed entry are stale and must be masked by the count.
// can_merge_o only looks at this entry; the allocator picks the newest one.

`default_nettype none

`include "lsb_macros.svh"

module sb_entry
  import lsb_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  mem_req_t  req_i,
  input  logic      write_i,
  input  logic      merge_i,
  output sb_entry_t entry_o,
  output logic      can_merge_o
);

  logic [`LSB_XLEN-1:2]  waddr_q;
  logic [`LSB_XLEN-1:0]  data_q;
  logic [`LSB_BYTES-1:0] strb_q;
  logic [`LSB_BYTES-1:0] new_strb;
  logic [`LSB_BYTES-1:0] comb_strb;
  logic [`LSB_XLEN-1:0]  new_data;

  assign new_strb  = byte_mask(req_i.addr[1:0], req_i.size);
  assign new_data  = req_i.data << {req_i.addr[1:0], 3'b000};  // Move into lanes
  assign comb_strb = strb_q | new_strb;

  assign can_merge_o = req_i.valid && req_i.is_store &&
                       (req_i.addr[`LSB_XLEN-1:2] == waddr_q) &&
                       (mask_size(comb_strb) != NO_SIZE);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      strb_q <= '0;
    end else if (write_i) begin
      strb_q <= new_strb;
    end else if (merge_i) begin
      strb_q <= comb_strb;
    end
  end

  always_ff @(posedge clk_i) begin
    if (write_i) begin
      waddr_q <= req_i.addr[`LSB_XLEN-1:2];
      data_q  <= new_data;
    end else if (merge_i) begin
      for (int b = 0; b < `LSB_BYTES; b++) begin
        if (new_strb[b]) begin
          data_q[b*8 +: 8] <= new_data[b*8 +: 8];  // Younger byte wins
        end
      end
    end
  end

  assign entry_o = '{waddr: waddr_q, data: data_q, strb: strb_q};

endmodule

`default_nettype wire

//--- logic/sb_forward.sv
// Store-to-load forwarding scan, purely combinational.
// Walks the occupied entries from newest to oldest; the first strobe found
// for a byte is the youngest value. Only full hits may be forwarded.

`default_nettype none

`include "lsb_macros.svh"

module sb_forward
  import lsb_pkg::*;
#(
  parameter int unsigned DEPTH = `LSB_DEPTH
) (
  input  sb_entry_t                  entries_i [DEPTH],
  input  logic [$clog2(DEPTH)-1:0]   newest_i,
  input  logic [$clog2(DEPTH+1)-1:0] count_i,
  input  mem_req_t                   req_i,
  output logic                       hit_o,
  output logic                       partial_o,
  output logic [`LSB_XLEN-1:0]       word_o
);

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

  logic                  load;
  logic [`LSB_BYTES-1:0] need;
  logic [`LSB_BYTES-1:0] found;
  logic [PTR_W-1:0]      ptr;

  assign load = req_i.valid && !req_i.is_store;
  assign need = byte_mask(req_i.addr[1:0], req_i.size);

  always_comb begin
    found  = '0;
    word_o = '0;
    ptr    = newest_i;
    for (int k = 0; k < DEPTH; k++) begin
      if ((CNT_W'(k) < count_i) && (entries_i[ptr].waddr == req_i.addr[`LSB_XLEN-1:2])) begin
        for (int b = 0; b < `LSB_BYTES; b++) begin
          if (entries_i[ptr].strb[b] && !found[b]) begin
            word_o[b*8 +: 8] = entries_i[ptr].data[b*8 +: 8];
          end
        end
        found = found | entries_i[ptr].strb;
      end
      ptr = (ptr == '0) ? LAST : ptr - 1'b1;  // Step to the next older entry
    end
  end

  assign hit_o     = load && (need != '0) && ((found & need) == need);
  assign partial_o = load && ((found & need) != '0) && !hit_o;

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Builds the load/store buffer testbench with Verilator and runs it.
# The exit status is nonzero unless the simulation prints its pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f files.f --top-module tb_ldst_buffer \
  -o tb_ldst_buffer &&
./obj_dir/tb_ldst_buffer | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- tests/tb_dcache_model.sv
// Data cache model for the testbench. 16 words of byte memory, addresses wrap
// at 64 bytes. One request at a time, answered 1 to 4 cycles later.
// Requests are sampled SAMPLE_DELAY after the falling edge, before the rising one.

`default_nettype none

module tb_dcache_model
  import lsb_pkg::*;
#(
  parameter int SAMPLE_DELAY = 2
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  dcache_req_t req_i,
  output dcache_res_t res_o
);

  logic [7:0]  mem [64];
  integer      seed;
  logic        busy;
  int          wait_cnt;
  int          protocol_errors;
  logic [31:0] rd_word;

  initial begin
    int base;
    int wbase;
    int n;
    seed            = 7;
    busy            = 1'b0;
    wait_cnt        = 0;
    protocol_errors = 0;
    rd_word         = '0;
    res_o           = '0;
    for (int i = 0; i < 64; i++) begin
      mem[i] = 8'((i * 29) ^ 8'hA5);  // Differs per address
    end
    forever begin
      @(negedge clk_i);
      res_o = '0;
      if (busy) begin
        if (wait_cnt == 0) begin
          res_o.valid = 1'b1;
          res_o.data  = rd_word;
          busy        = 1'b0;
        end else begin
          wait_cnt--;
        end
      end
      #SAMPLE_DELAY;
      if (rst_ni && req_i.valid) begin
        if (busy) begin
          protocol_errors++;
          $display("Cache model: request at %0t while a transaction is open", $time);
        end
        base  = int'(req_i.addr[5:0]);
        wbase = base & 60;
        if (req_i.is_store) begin
          n = (req_i.size == WORD) ? 4 : (req_i.size == HALF) ? 2 : 1;
          for (int i = 0; i < n; i++) begin
            mem[base + i] = req_i.data[8*i +: 8];  // Low bits hold the data
          end
        end
        rd_word  = {mem[wbase + 3], mem[wbase + 2], mem[wbase + 1], mem[wbase]};
        busy     = 1'b1;
        wait_cnt = $unsigned($random(seed)) % 4;
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_ldst_buffer.sv
// Testbench for the load/store buffer. Accesses cover a 16-word window and are
// naturally aligned. The reference is a byte array updated at acceptance.
// Cache memory is compared through the model instance after each drain.

`default_nettype none

`include "lsb_macros.svh"

module tb_ldst_buffer
  import lsb_pkg::*;
();

  localparam int DEPTH  = `LSB_DEPTH;
  localparam int HALF_P = 5;
  localparam int SAMPLE = 4;                      // Just before the rising edge
  localparam int N_OPS  = 450;                    // Accesses and drains in all tests
  localparam int LIMIT  = N_OPS * (DEPTH + 2) * 5;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        flush;
  mem_req_t    req;
  logic        stall;
  logic        ld_valid;
  logic [31:0] ld_data;
  dcache_req_t dc_req;
  dcache_res_t dc_res;

  logic [7:0] ref_mem [64];
  integer     seed;
  int         cycles = 0;
  int         checks = 0;
  int         errors = 0;
  int         checks_mark = 0;
  int         errors_mark = 0;

  always #HALF_P clk = ~clk;

  ldst_buffer ldst_buffer_i (
    .clk_i(clk), .rst_ni(rst_n), .flush_i(flush), .req_i(req),
    .stall_o(stall), .ld_valid_o(ld_valid), .ld_data_o(ld_data),
    .dcache_req_o(dc_req), .dcache_res_i(dc_res)
  );

  tb_dcache_model dcache_model_i (
    .clk_i(clk), .rst_ni(rst_n), .req_i(dc_req), .res_o(dc_res)
  );

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Timeout: the run hung, no finish after %0d cycles", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    $display("%s done: %0d checks, %0d errors", name, checks - checks_mark,
             errors - errors_mark);
    checks_mark = checks;
    errors_mark = errors;
  endtask

  // ==========================================================================
  // Reference model
  // ==========================================================================
  function automatic int size_bytes(input size_e sz);
    case (sz)
      BYTE:    return 1;
      HALF:    return 2;
      WORD:    return 4;
      default: return 0;
    endcase
  endfunction

  function automatic logic [31:0] expected_load(input logic [31:0] addr, input size_e sz,
                                                input logic sgn);
    logic [31:0] w;
    int          n;
    n = size_bytes(sz);
    w = '0;
    for (int i = 0; i < n; i++) begin
      w[8*i +: 8] = ref_mem[int'(addr[5:0]) + i];
    end
    if (sgn && (n < 4) && w[8*n-1]) begin
      for (int i = n; i < 4; i++) begin
        w[8*i +: 8] = 8'hff;
      end
    end
    return w;
  endfunction

  function automatic logic cache_differs();
    for (int i = 0; i < 64; i++) begin
      if (dcache_model_i.mem[i] !== ref_mem[i]) return 1'b1;
    end
    return 1'b0;
  endfunction

  // ==========================================================================
  // Stimulus tasks start and end just after a falling edge
  // ==========================================================================
  task automatic access(input logic st, input logic [3:0] widx, input logic [1:0] lsb,
                        input size_e sz, input logic sgn, input logic [31:0] data,
                        output int stalls);
    logic [31:0] addr;
    logic        done;
    addr         = {26'd0, widx, lsb};
    req          = '0;
    req.valid    = 1'b1;
    req.is_store = st;
    req.addr     = addr;
    req.size     = sz;
    req.sign     = sgn;
    req.data     = data;
    stalls       = 0;
    done         = 1'b0;
    while (!done) begin
      #SAMPLE;
      check_value("ld_valid_o", 32'(ld_valid), 32'(!st && !stall));
      if (dc_req.valid && !dc_req.is_store) begin
        check_value("dcache_req_o.addr", dc_req.addr, addr);
        check_value("dcache_req_o.size", 32'(dc_req.size), 32'(sz));
      end
      if (stall) begin
        stalls++;  // Request stays unchanged
      end else begin
        done = 1'b1;
        if (st) begin
          for (int i = 0; i < size_bytes(sz); i++) begin
            ref_mem[int'(addr[5:0]) + i] = data[8*i +: 8];
          end
        end else begin
          check_value("ld_data_o", ld_data, expected_load(addr, sz, sgn));
        end
      end
      @(negedge clk);
    end
    req = '0;
  endtask

  task automatic random_access(input logic store_only, output int stalls);
    logic [31:0] r;
    logic [31:0] data;
    logic        st;
    logic [1:0]  lsb;
    size_e       sz;
    r    = $random(seed);
    data = $random(seed);
    st   = store_only | r[0];
    lsb  = r[3:2];
    case (r[9:8])
      2'd0:    sz = BYTE;
      2'd1:    sz = HALF;
      default: sz = WORD;
    endcase
    if (sz == HALF) lsb[0] = 1'b0;
    if (sz == WORD) lsb = 2'd0;
    access(st, r[7:4], lsb, sz, r[1] & !st, data, stalls);
  endtask

  task automatic flush_and_drain();
    logic pending;
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    #SAMPLE;
    pending = cache_differs();  // Some store is still buffered
    if (pending) check_value("stall_o", 32'(stall), 32'd1);
    while (stall) begin
      @(negedge clk);
      #SAMPLE;
    end
    for (int i = 0; i < 64; i++) begin
      check_value($sformatf("cache byte %0d", i), 32'(dcache_model_i.mem[i]),
                  32'(ref_mem[i]));
    end
    @(negedge clk);
  endtask

  initial begin
    int          s;
    int          total;
    logic [31:0] data;
    seed  = 7;
    rst_n = 1'b0;
    flush = 1'b0;
    req   = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < 64; i++) begin
      ref_mem[i] = dcache_model_i.mem[i];
    end

    // Filler word stores keep the port busy so the byte stores can merge
    for (int k = 0; k < 4; k++) begin
      for (int f = 0; f <= k; f++) begin
        access(1'b1, 4'(f), 2'd0, WORD, 1'b0, $random(seed), s);
      end
      access(1'b1, 4'(k + 4), 2'd0, BYTE, 1'b0, $random(seed), s);
      access(1'b1, 4'(k + 4), 2'd1, BYTE, 1'b0, $random(seed), s);
      access(1'b1, 4'(k + 4), 2'd2, HALF, 1'b0, $random(seed), s);
      access(1'b0, 4'(k + 4), 2'd0, WORD, 1'b0, '0, s);
      access(1'b0, 4'(k + 4), 2'd2, HALF, 1'b1, '0, s);
    end
    end_test("merge_forward");

    for (int w = 8; w < 12; w++) begin
      data = ($random(seed) & 32'h7F7F_7F7F) | 32'h8000_0080;  // Mixed sign bits
      access(1'b1, 4'(w), 2'd0, WORD, 1'b0, data, s);
    end
    flush_and_drain();
    for (int w = 8; w < 10; w++) begin
      for (int sg = 0; sg < 2; sg++) begin
        for (int b = 0; b < 4; b++) begin
          access(1'b0, 4'(w), 2'(b), BYTE, 1'(sg), '0, s);
        end
        access(1'b0, 4'(w), 2'd0, HALF, 1'(sg), '0, s);
        access(1'b0, 4'(w), 2'd2, HALF, 1'(sg), '0, s);
      end
    end
    end_test("extension");

    total = 0;
    for (int i = 0; i < 3 * DEPTH; i++) begin
      access(1'b1, 4'(i), 2'd0, WORD, 1'b0, $random(seed), s);
      total += s;
    end
    check_value("store stall cycles seen", 32'(total > 0), 32'd1);
    for (int i = 0; i < 3 * DEPTH; i++) begin
      access(1'b0, 4'(i), 2'd0, WORD, 1'b0, '0, s);
    end
    end_test("back_pressure");

    for (int i = 0; i < 2 * DEPTH; i++) begin
      random_access(1'b1, s);
    end
    flush_and_drain();
    end_test("flush");

    for (int i = 0; i < 300; i++) begin
      random_access(1'b0, s);
      if (($unsigned($random(seed)) % 16) == 0) flush_and_drain();
    end
    flush_and_drain();
    end_test("random_mix");

    errors += dcache_model_i.protocol_errors;
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
